// ==== hdl/issuePkg.sv ====
`default_nettype none

package issuePkg;

    // Register and queue geometry
    localparam int TAG_BITS = 5;
    localparam int NUM_PREGS = 32;
    localparam int IQ_SIZE = 8;
    localparam int SQN_BITS = 6;

    // Issue to result latencies in cycles
    localparam int MUL_LAT = 3;
    localparam int ALU_LAT = 1;

    typedef logic [TAG_BITS-1:0] Tag;

    // Age is the wraparound-signed difference of two of these
    typedef logic [SQN_BITS-1:0] SqN;

    typedef logic [31:0] Word;

    typedef logic [$clog2(IQ_SIZE)-1:0] IqIdx;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_XOR,
        OP_SLL,
        OP_MUL
    } Opcode;

endpackage

`default_nettype wire

// ==== hdl/priorityEncoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module priorityEncoder (
    input  wire logic [issuePkg::IQ_SIZE-1:0] req,
    output issuePkg::IqIdx                    idx,
    output logic                              found
);

    // Scan from the top so the lowest set bit wins
    always_comb begin
        idx = '0;
        found = 1'b0;
        for (int i = issuePkg::IQ_SIZE - 1; i >= 0; i--) begin
            if (req[i]) begin
                idx = issuePkg::IqIdx'(i);
                found = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/issueQueue.sv ====
`timescale 1ns/1ps
`default_nettype none

module issueQueue (
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire logic           dispValid,
    input  issuePkg::Opcode     dispOpcode,
    input  issuePkg::Tag        dispTagA,
    input  wire logic           dispAvailA,
    input  issuePkg::Tag        dispTagB,
    input  wire logic           dispAvailB,
    input  wire logic           dispImmB,
    input  issuePkg::Word       dispImm,
    input  issuePkg::Tag        dispTagDst,
    input  issuePkg::SqN        dispSqN,
    input  wire logic           flushValid,
    input  issuePkg::SqN        flushSqN,
    input  wire logic           resValid,
    input  issuePkg::Tag        resTag,
    output logic                full,
    output logic                issValid,
    output issuePkg::Opcode     issOpcode,
    output issuePkg::Tag        issTagA,
    output issuePkg::Tag        issTagB,
    output issuePkg::Tag        issTagDst,
    output logic                issImmB,
    output issuePkg::Word       issImm
);

    typedef logic [$clog2(issuePkg::IQ_SIZE):0] Count;

    // Entry storage, index 0 is the oldest
    issuePkg::Opcode opcodeQ [issuePkg::IQ_SIZE];
    issuePkg::Tag    tagAQ   [issuePkg::IQ_SIZE];
    issuePkg::Tag    tagBQ   [issuePkg::IQ_SIZE];
    issuePkg::Tag    tagDstQ [issuePkg::IQ_SIZE];
    issuePkg::Word   immQ    [issuePkg::IQ_SIZE];
    issuePkg::SqN    sqNQ    [issuePkg::IQ_SIZE];
    logic [issuePkg::IQ_SIZE-1:0] immBQ;
    logic [issuePkg::IQ_SIZE-1:0] availAQ;
    logic [issuePkg::IQ_SIZE-1:0] availBQ;

    Count insertIndex;
    Count flushInsert;
    Count enqIndex;

    // Bit 0 marks a result bus slot already claimed by a multiply
    logic [issuePkg::MUL_LAT-1:0] resvWb;

    logic [issuePkg::IQ_SIZE-1:0] wakeA;
    logic [issuePkg::IQ_SIZE-1:0] wakeB;
    logic [issuePkg::IQ_SIZE-1:0] ready;

    issuePkg::IqIdx selIdx;
    logic selFound;
    logic enqFire;
    logic newAvailA;
    logic newAvailB;

    assign full = (insertIndex == Count'(issuePkg::IQ_SIZE));

    // Wakeup from the result bus
    always_comb begin
        for (int i = 0; i < issuePkg::IQ_SIZE; i++) begin
            wakeA[i] = resValid && (tagAQ[i] == resTag);
            wakeB[i] = resValid && (tagBQ[i] == resTag);
        end
    end

    // A simple op may not land in a slot held by a multiply
    always_comb begin
        for (int i = 0; i < issuePkg::IQ_SIZE; i++) begin
            ready[i] = (Count'(i) < insertIndex) &&
                       (availAQ[i] || wakeA[i]) &&
                       (availBQ[i] || wakeB[i]) &&
                       (opcodeQ[i] == issuePkg::OP_MUL || !resvWb[0]);
        end
    end

    priorityEncoder selEnc (
        .req   (ready),
        .idx   (selIdx),
        .found (selFound)
    );

    // Keep everything up to the last entry not younger than the flush
    always_comb begin
        flushInsert = '0;
        for (int i = 0; i < issuePkg::IQ_SIZE; i++) begin
            if (Count'(i) < insertIndex && $signed(sqNQ[i] - flushSqN) <= 0) begin
                flushInsert = Count'(i + 1);
            end
        end
    end

    assign enqFire = dispValid && !full;
    assign enqIndex = insertIndex - Count'(selFound);

    // Same-cycle wakeup for the op being dispatched
    assign newAvailA = dispAvailA || (resValid && dispTagA == resTag);
    assign newAvailB = dispAvailB || dispImmB || (resValid && dispTagB == resTag);

    always_ff @(posedge clk) begin
        availAQ <= availAQ | wakeA;
        availBQ <= availBQ | wakeB;
        resvWb <= resvWb >> 1;

        if (rst) begin
            insertIndex <= '0;
            resvWb <= '0;
            issValid <= 1'b0;
        end else if (flushValid) begin
            // No select and no dispatch on a flush edge
            insertIndex <= flushInsert;
            issValid <= 1'b0;
        end else begin
            issValid <= selFound;

            if (selFound) begin
                issOpcode <= opcodeQ[selIdx];
                issTagA <= tagAQ[selIdx];
                issTagB <= tagBQ[selIdx];
                issTagDst <= tagDstQ[selIdx];
                issImmB <= immBQ[selIdx];
                issImm <= immQ[selIdx];

                if (opcodeQ[selIdx] == issuePkg::OP_MUL) begin
                    resvWb <= (resvWb >> 1) |
                              (issuePkg::MUL_LAT'(1) <<
                               (issuePkg::MUL_LAT - issuePkg::ALU_LAT - 1));
                end

                // Collapse younger entries over the issued one
                for (int i = 0; i < issuePkg::IQ_SIZE - 1; i++) begin
                    if (i >= selIdx) begin
                        opcodeQ[i] <= opcodeQ[i+1];
                        tagAQ[i] <= tagAQ[i+1];
                        tagBQ[i] <= tagBQ[i+1];
                        tagDstQ[i] <= tagDstQ[i+1];
                        immQ[i] <= immQ[i+1];
                        sqNQ[i] <= sqNQ[i+1];
                        immBQ[i] <= immBQ[i+1];
                        availAQ[i] <= availAQ[i+1] | wakeA[i+1];
                        availBQ[i] <= availBQ[i+1] | wakeB[i+1];
                    end
                end
            end

            // Append after the collapse so it lands on the new tail
            if (enqFire) begin
                opcodeQ[issuePkg::IqIdx'(enqIndex)] <= dispOpcode;
                tagAQ[issuePkg::IqIdx'(enqIndex)] <= dispTagA;
                tagBQ[issuePkg::IqIdx'(enqIndex)] <= dispTagB;
                tagDstQ[issuePkg::IqIdx'(enqIndex)] <= dispTagDst;
                immQ[issuePkg::IqIdx'(enqIndex)] <= dispImm;
                sqNQ[issuePkg::IqIdx'(enqIndex)] <= dispSqN;
                immBQ[issuePkg::IqIdx'(enqIndex)] <= dispImmB;
                availAQ[issuePkg::IqIdx'(enqIndex)] <= newAvailA;
                availBQ[issuePkg::IqIdx'(enqIndex)] <= newAvailB;
            end

            insertIndex <= enqIndex + Count'(enqFire);
        end
    end

endmodule

`default_nettype wire

// ==== hdl/physRegFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module physRegFile (
    input  wire logic    clk,
    input  wire logic    rst,
    input  issuePkg::Tag rdTagA,
    input  issuePkg::Tag rdTagB,
    input  wire logic    wrValid,
    input  issuePkg::Tag wrTag,
    input  issuePkg::Word wrData,
    output issuePkg::Word rdDataA,
    output issuePkg::Word rdDataB
);

    issuePkg::Word regs [issuePkg::NUM_PREGS];

    // Register 0 reads zero, a same-cycle write is bypassed
    function automatic issuePkg::Word readPort(input issuePkg::Tag tag);
        issuePkg::Word value;
        if (tag == '0) begin
            value = '0;
        end else if (wrValid && wrTag == tag) begin
            value = wrData;
        end else begin
            value = regs[tag];
        end
        return value;
    endfunction

    assign rdDataA = readPort(rdTagA);
    assign rdDataB = readPort(rdTagB);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < issuePkg::NUM_PREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wrValid && wrTag != '0) begin
            regs[wrTag] <= wrData;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/intExecUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module intExecUnit (
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire logic      issValid,
    input  issuePkg::Opcode issOpcode,
    input  wire logic      issImmB,
    input  issuePkg::Word  issImm,
    input  issuePkg::Tag   issTagDst,
    input  issuePkg::Word  srcA,
    input  issuePkg::Word  srcB,
    output logic           resValid,
    output issuePkg::Tag   resTag,
    output issuePkg::Word  resData
);

    issuePkg::Word opB;
    issuePkg::Word aluOut;

    // Multiply pipeline, two stages ahead of the result register
    logic          mul1Valid;
    issuePkg::Tag  mul1Tag;
    issuePkg::Word mul1A;
    issuePkg::Word mul1B;
    logic          mul2Valid;
    issuePkg::Tag  mul2Tag;
    issuePkg::Word mul2Prod;

    assign opB = issImmB ? issImm : srcB;

    always_comb begin
        case (issOpcode)
            issuePkg::OP_ADD: aluOut = srcA + opB;
            issuePkg::OP_SUB: aluOut = srcA - opB;
            issuePkg::OP_AND: aluOut = srcA & opB;
            issuePkg::OP_XOR: aluOut = srcA ^ opB;
            issuePkg::OP_SLL: aluOut = srcA << opB[4:0];
            default: aluOut = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        mul1A <= srcA;
        mul1B <= opB;
        mul1Tag <= issTagDst;
        mul2Prod <= mul1A * mul1B;
        mul2Tag <= mul1Tag;

        // The queue never lets both paths finish in one cycle
        if (mul2Valid) begin
            resTag <= mul2Tag;
            resData <= mul2Prod;
        end else begin
            resTag <= issTagDst;
            resData <= aluOut;
        end

        if (rst) begin
            mul1Valid <= 1'b0;
            mul2Valid <= 1'b0;
            resValid <= 1'b0;
        end else begin
            mul1Valid <= issValid && issOpcode == issuePkg::OP_MUL;
            mul2Valid <= mul1Valid;
            resValid <= mul2Valid || (issValid && issOpcode != issuePkg::OP_MUL);
        end
    end

endmodule

`default_nettype wire

// ==== hdl/issueCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module issueCore (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       dispValid,
    input  issuePkg::Opcode dispOpcode,
    input  issuePkg::Tag    dispTagA,
    input  wire logic       dispAvailA,
    input  issuePkg::Tag    dispTagB,
    input  wire logic       dispAvailB,
    input  wire logic       dispImmB,
    input  issuePkg::Word   dispImm,
    input  issuePkg::Tag    dispTagDst,
    input  issuePkg::SqN    dispSqN,
    input  wire logic       flushValid,
    input  issuePkg::SqN    flushSqN,
    output logic            full,
    output logic            resValid,
    output issuePkg::Tag    resTag,
    output issuePkg::Word   resData
);

    // Issue bundle
    logic            issValid;
    issuePkg::Opcode issOpcode;
    issuePkg::Tag    issTagA;
    issuePkg::Tag    issTagB;
    issuePkg::Tag    issTagDst;
    logic            issImmB;
    issuePkg::Word   issImm;

    // Operand values
    issuePkg::Word srcA;
    issuePkg::Word srcB;

    issueQueue queue0 (
        .clk        (clk),
        .rst        (rst),
        .dispValid  (dispValid),
        .dispOpcode (dispOpcode),
        .dispTagA   (dispTagA),
        .dispAvailA (dispAvailA),
        .dispTagB   (dispTagB),
        .dispAvailB (dispAvailB),
        .dispImmB   (dispImmB),
        .dispImm    (dispImm),
        .dispTagDst (dispTagDst),
        .dispSqN    (dispSqN),
        .flushValid (flushValid),
        .flushSqN   (flushSqN),
        .resValid   (resValid),
        .resTag     (resTag),
        .full       (full),
        .issValid   (issValid),
        .issOpcode  (issOpcode),
        .issTagA    (issTagA),
        .issTagB    (issTagB),
        .issTagDst  (issTagDst),
        .issImmB    (issImmB),
        .issImm     (issImm)
    );

    physRegFile prf0 (
        .clk     (clk),
        .rst     (rst),
        .rdTagA  (issTagA),
        .rdTagB  (issTagB),
        .wrValid (resValid),
        .wrTag   (resTag),
        .wrData  (resData),
        .rdDataA (srcA),
        .rdDataB (srcB)
    );

    intExecUnit exec0 (
        .clk       (clk),
        .rst       (rst),
        .issValid  (issValid),
        .issOpcode (issOpcode),
        .issImmB   (issImmB),
        .issImm    (issImm),
        .issTagDst (issTagDst),
        .srcA      (srcA),
        .srcB      (srcB),
        .resValid  (resValid),
        .resTag    (resTag),
        .resData   (resData)
    );

endmodule

`default_nettype wire

// ==== sim/issueCoreTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module issueCoreTb;

    localparam int CLK_HALF = 4;
    localparam int DRAIN_LIMIT = 60;
    localparam int FULL_LIMIT = 10;
    localparam int QUIET_CYCLES = 40;

    // Row kinds of the stimulus table
    localparam int K_OP = 0;
    localparam int K_DEAD = 1;
    localparam int K_FLUSH = 2;
    localparam int K_DRAIN = 3;
    localparam int K_FULL = 4;
    localparam int K_NOTFULL = 5;

    logic            clk;
    logic            rst;
    logic            dispValid;
    issuePkg::Opcode dispOpcode;
    issuePkg::Tag    dispTagA;
    logic            dispAvailA;
    issuePkg::Tag    dispTagB;
    logic            dispAvailB;
    logic            dispImmB;
    issuePkg::Word   dispImm;
    issuePkg::Tag    dispTagDst;
    issuePkg::SqN    dispSqN;
    logic            flushValid;
    issuePkg::SqN    flushSqN;
    logic            full;
    logic            resValid;
    issuePkg::Tag    resTag;
    issuePkg::Word   resData;

    // Stimulus table, one row per action
    string           nameTab[$];
    int              kindTab[$];
    issuePkg::Opcode opTab[$];
    int              tagATab[$];
    int              tagBTab[$];
    logic            immBTab[$];
    issuePkg::Word   immTab[$];
    int              dstTab[$];
    int              sqNTab[$];
    int              idleTab[$];
    int              afterTab[$];

    // Reference register state and per-tag scoreboard
    issuePkg::Word modelRegs [issuePkg::NUM_PREGS];
    issuePkg::Word expData   [issuePkg::NUM_PREGS];
    logic          pending   [issuePkg::NUM_PREGS];
    logic          written   [issuePkg::NUM_PREGS];
    logic          dead      [issuePkg::NUM_PREGS];
    int            afterOf   [issuePkg::NUM_PREGS];
    string         tagName   [issuePkg::NUM_PREGS];

    int errors;
    int pendingCount;
    int gotCount;
    int expectCount;

    issueCore dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    function automatic issuePkg::Word modelOp(input issuePkg::Opcode op,
                                              input issuePkg::Word a,
                                              input issuePkg::Word b);
        issuePkg::Word r;
        case (op)
            issuePkg::OP_ADD: r = a + b;
            issuePkg::OP_SUB: r = a - b;
            issuePkg::OP_AND: r = a & b;
            issuePkg::OP_XOR: r = a ^ b;
            issuePkg::OP_SLL: r = a << b[4:0];
            issuePkg::OP_MUL: r = a * b;
            default: r = '0;
        endcase
        return r;
    endfunction

    task automatic addRow(input string name, input int kind, input issuePkg::Opcode op,
                          input int tagA, input int tagB, input logic immB,
                          input issuePkg::Word imm, input int dst, input int sqN,
                          input int idle, input int after);
        nameTab.push_back(name);
        kindTab.push_back(kind);
        opTab.push_back(op);
        tagATab.push_back(tagA);
        tagBTab.push_back(tagB);
        immBTab.push_back(immB);
        immTab.push_back(imm);
        dstTab.push_back(dst);
        sqNTab.push_back(sqN);
        idleTab.push_back(idle);
        afterTab.push_back(after);
    endtask

    task automatic addCtl(input string name, input int kind, input int sqN);
        addRow(name, kind, issuePkg::OP_ADD, 0, 0, 1'b0, '0, 0, sqN, 0, 0);
    endtask

    task automatic buildTable();
        // Immediate loads, then every simple opcode on them
        addRow("ldA", K_OP, issuePkg::OP_ADD, 0, 0, 1, 32'h0000_1234, 1, 1, 0, 0);
        addRow("ldB", K_OP, issuePkg::OP_ADD, 0, 0, 1, 32'hf0f0_00ff, 2, 2, 0, 0);
        addRow("ldC", K_OP, issuePkg::OP_ADD, 0, 0, 1, 32'd5, 3, 3, 0, 0);
        addRow("opAdd", K_OP, issuePkg::OP_ADD, 1, 2, 0, '0, 4, 4, 0, 0);
        addRow("opSub", K_OP, issuePkg::OP_SUB, 1, 2, 0, '0, 5, 5, 0, 0);
        addRow("opAnd", K_OP, issuePkg::OP_AND, 1, 2, 0, '0, 6, 6, 0, 0);
        addRow("opXor", K_OP, issuePkg::OP_XOR, 1, 2, 0, '0, 7, 7, 0, 0);
        addRow("opSll", K_OP, issuePkg::OP_SLL, 2, 3, 0, '0, 8, 8, 0, 0);
        addCtl("drainBasic", K_DRAIN, 0);
        // chainSame is dispatched in the cycle tag 9 is on the bus
        addRow("chainLd", K_OP, issuePkg::OP_ADD, 0, 0, 1, 32'd100, 9, 9, 0, 0);
        addRow("chainAdd", K_OP, issuePkg::OP_ADD, 9, 0, 1, 32'd7, 10, 10, 0, 0);
        addRow("chainSub", K_OP, issuePkg::OP_SUB, 10, 9, 0, '0, 11, 11, 0, 0);
        addRow("chainSame", K_OP, issuePkg::OP_ADD, 9, 0, 1, 32'd3, 12, 12, 0, 0);
        addRow("chainXor", K_OP, issuePkg::OP_XOR, 11, 12, 0, '0, 13, 13, 0, 0);
        addCtl("drainChain", K_DRAIN, 0);
        // Multiply consumer must finish after the younger independent ops
        addRow("oooMul", K_OP, issuePkg::OP_MUL, 1, 2, 0, '0, 14, 14, 0, 0);
        addRow("oooDep", K_OP, issuePkg::OP_MUL, 14, 0, 1, 32'd3, 15, 15, 0, 17);
        addRow("oooInd1", K_OP, issuePkg::OP_ADD, 0, 0, 1, 32'h55, 16, 16, 0, 0);
        addRow("oooInd2", K_OP, issuePkg::OP_XOR, 3, 0, 1, 32'hff, 17, 17, 0, 0);
        addCtl("drainOoo", K_DRAIN, 0);
        addRow("mixMul0", K_OP, issuePkg::OP_MUL, 1, 0, 1, 32'd7, 18, 18, 0, 0);
        addRow("mixAdd0", K_OP, issuePkg::OP_ADD, 2, 0, 1, 32'd1, 19, 19, 0, 0);
        addRow("mixMul1", K_OP, issuePkg::OP_MUL, 3, 2, 0, '0, 20, 20, 0, 0);
        addRow("mixSll0", K_OP, issuePkg::OP_SLL, 1, 0, 1, 32'd4, 21, 21, 0, 0);
        addRow("mixMul2", K_OP, issuePkg::OP_MUL, 4, 0, 1, 32'd9, 22, 22, 0, 0);
        addRow("mixAnd0", K_OP, issuePkg::OP_AND, 5, 6, 0, '0, 23, 23, 0, 0);
        addCtl("drainMix", K_DRAIN, 0);
        // Tag 30 is never produced, so the young ops can only leave by flush
        addRow("flOldMul", K_OP, issuePkg::OP_MUL, 7, 0, 1, 32'd3, 24, 24, 0, 0);
        addRow("flOldDep", K_OP, issuePkg::OP_SUB, 24, 1, 0, '0, 25, 25, 0, 0);
        addRow("flYoung0", K_DEAD, issuePkg::OP_ADD, 30, 0, 1, 32'd1, 26, 26, 0, 0);
        addRow("flYoung1", K_DEAD, issuePkg::OP_XOR, 30, 2, 0, '0, 27, 27, 0, 0);
        addCtl("flushYoung", K_FLUSH, 25);
        addCtl("drainFlush", K_DRAIN, 0);
        for (int i = 0; i < issuePkg::IQ_SIZE; i++) begin
            // Room left by the flushed young ops keeps the queue one short of full
            if (i == issuePkg::IQ_SIZE - 1) begin
                addRow("fullNotYet", K_NOTFULL, issuePkg::OP_ADD, 0, 0, 1'b0, '0, 0, 0, 1, 0);
            end
            addRow($sformatf("fill%0d", i), K_DEAD, issuePkg::OP_ADD, 30, 0, 1,
                   issuePkg::Word'(i), 31, 28 + i, 0, 0);
        end
        addCtl("fullHigh", K_FULL, 0);
        addCtl("flushAll", K_FLUSH, 27);
        addCtl("fullLow", K_NOTFULL, 0);
    endtask

    // Result bus as it was during the cycle that just ended
    task automatic checkResult();
        int t;
        if (resValid) begin
            t = int'(resTag);
            assert (!dead[t] && pending[t]) else begin
                errors++;
                if (dead[t]) begin
                    $display("Test %s: flushed tag %0d appeared on the result bus",
                             tagName[t], t);
                end else begin
                    $display("Tag %0d produced a result that was not expected", t);
                end
            end
            if (pending[t]) begin
                assert (resData == expData[t]) else begin
                    errors++;
                    $display("FAIL %s: expected %h, actual %h", tagName[t], expData[t], resData);
                end
                assert (afterOf[t] == 0 || written[afterOf[t]]) else begin
                    errors++;
                    $display("Test %s finished before tag %0d", tagName[t], afterOf[t]);
                end
                pending[t] = 1'b0;
                written[t] = 1'b1;
                pendingCount--;
                gotCount++;
            end
        end
    endtask

    task automatic step();
        @(posedge clk);
        checkResult();
        dispValid <= 1'b0;
        flushValid <= 1'b0;
    endtask

    task automatic dispatchRow(input int r);
        int a;
        int b;
        int d;
        issuePkg::Word opB;
        a = tagATab[r];
        b = tagBTab[r];
        d = dstTab[r];
        dispValid <= 1'b1;
        dispOpcode <= opTab[r];
        dispTagA <= issuePkg::Tag'(a);
        dispAvailA <= (a == 0) || written[a];
        dispTagB <= issuePkg::Tag'(b);
        dispAvailB <= immBTab[r] || (b == 0) || written[b];
        dispImmB <= immBTab[r];
        dispImm <= immTab[r];
        dispTagDst <= issuePkg::Tag'(d);
        dispSqN <= issuePkg::SqN'(sqNTab[r]);
        tagName[d] = nameTab[r];
        if (kindTab[r] == K_DEAD) begin
            dead[d] = 1'b1;
        end else begin
            opB = immBTab[r] ? immTab[r] : modelRegs[b];
            modelRegs[d] = modelOp(opTab[r], modelRegs[a], opB);
            expData[d] = modelRegs[d];
            afterOf[d] = afterTab[r];
            pending[d] = 1'b1;
            pendingCount++;
            expectCount++;
        end
    endtask

    task automatic drainResults();
        int waited;
        waited = 0;
        while (pendingCount > 0 && waited < DRAIN_LIMIT) begin
            step();
            waited++;
        end
        assert (pendingCount == 0) else begin
            errors++;
            for (int t = 0; t < issuePkg::NUM_PREGS; t++) begin
                if (pending[t]) begin
                    $display("Test %s timed out waiting for tag %0d", tagName[t], t);
                    pending[t] = 1'b0;
                end
            end
            pendingCount = 0;
        end
    endtask

    task automatic waitFull(input int r, input logic level);
        int waited;
        waited = 0;
        while (full !== level && waited < FULL_LIMIT) begin
            step();
            waited++;
        end
        assert (full === level) else begin
            errors++;
            $display("Test %s: full did not go %s in time", nameTab[r], level ? "high" : "low");
        end
    endtask

    initial begin
        rst = 1'b1;
        dispValid = 1'b0;
        dispOpcode = issuePkg::OP_ADD;
        dispTagA = '0;
        dispAvailA = 1'b0;
        dispTagB = '0;
        dispAvailB = 1'b0;
        dispImmB = 1'b0;
        dispImm = '0;
        dispTagDst = '0;
        dispSqN = '0;
        flushValid = 1'b0;
        flushSqN = '0;
        errors = 0;
        pendingCount = 0;
        gotCount = 0;
        expectCount = 0;
        for (int t = 0; t < issuePkg::NUM_PREGS; t++) begin
            modelRegs[t] = '0;
            expData[t] = '0;
            pending[t] = 1'b0;
            written[t] = 1'b0;
            dead[t] = 1'b0;
            afterOf[t] = 0;
            tagName[t] = "none";
        end
        buildTable();

        repeat (2) @(posedge clk);
        rst <= 1'b0;

        for (int r = 0; r < nameTab.size(); r++) begin
            repeat (idleTab[r]) step();
            case (kindTab[r])
                K_OP, K_DEAD: begin
                    step();
                    dispatchRow(r);
                end
                K_FLUSH: begin
                    step();
                    flushValid <= 1'b1;
                    flushSqN <= issuePkg::SqN'(sqNTab[r]);
                end
                K_DRAIN: drainResults();
                K_FULL: waitFull(r, 1'b1);
                K_NOTFULL: waitFull(r, 1'b0);
                default: ;
            endcase
        end

        // Flushed tags must stay off the bus for the whole window
        repeat (QUIET_CYCLES) step();

        assert (gotCount == expectCount) else begin
            errors++;
            $display("FAIL resultCount: expected %0d, actual %0d", expectCount, gotCount);
        end
        $display("Results %0d of %0d, errors %0d", gotCount, expectCount, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
hdl/issuePkg.sv
hdl/priorityEncoder.sv
hdl/issueQueue.sv
hdl/physRegFile.sv
hdl/intExecUnit.sv
hdl/issueCore.sv
sim/issueCoreTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -Wno-fatal
TOP ?= issueCoreTb
FLIST ?= flist.f
OBJDIR ?= obj_dir
PASS_MSG ?= Simulation passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
